// ==== afi_rd_macros.svh ====
////////////////////////////////////////
// afi read path sizing
// widths and depths shared by the read-return blocks.
////////////////////////////////////////
`ifndef AFI_RD_MACROS_SVH
`define AFI_RD_MACROS_SVH

// read latency setting, one shifter tap per value.
`define AFI_LAT_W 4
`define AFI_LAT_NUM (2 ** `AFI_LAT_W)

// memory word is data plus one even parity bit.
`define AFI_DATA_W 32
`define AFI_WORD_W (`AFI_DATA_W + 1)

`define AFI_FIFO_DEPTH 4 // return buffer entries.

`define AFI_CNT_W 16 // returned read counter.
`define AFI_PEND_W 5 // outstanding read counter.

`endif

// ==== afi_rd_pkg.sv ====
////////////////////////////////////////
// afi read path types
// command opcodes and return checker states.
////////////////////////////////////////
`default_nettype none

package afi_rd_pkg;

	////////////////////////////////////////
	// afi command opcode, valid every cycle.
	typedef enum logic [1:0]
	{
		CMD_NOP     = 2'b00, // idle slot.
		CMD_READ    = 2'b01, // starts a latency count.
		CMD_WRITE   = 2'b10, // no return data.
		CMD_REFRESH = 2'b11  // no return data.
	} afi_cmd_e;

	////////////////////////////////////////
	// return checker
	typedef enum logic [1:0]
	{
		RET_IDLE = 2'b00, // nothing held.
		RET_POP  = 2'b01, // word latched, emitted at next edge.
		RET_EMIT = 2'b10  // strobe out, nothing held.
	} ret_state_e;

endpackage

`default_nettype wire

// ==== afi_cmd_tracker.sv ====
////////////////////////////////////////
// afi command tracker
// decodes opcodes, feeds reads into the latency
// shifter and counts reads still outstanding.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module afi_cmd_tracker
(
	input  wire                        pll_afi_clk,
	input  wire                        reset_n,
	input  afi_rd_pkg::afi_cmd_e       afi_cmd,
	input  wire                        read_valid,
	output logic [`AFI_LAT_NUM-1:0]    latency_shifter,
	output logic [`AFI_PEND_W-1:0]     reads_pending
);

	logic is_read; // current slot carries a read.
	logic read_q;  // read slot one edge later.

	////////////////////////////////////////
	// opcode decode
	always_comb
	begin
		case (afi_cmd)
			afi_rd_pkg::CMD_READ:    is_read = 1'b1;
			afi_rd_pkg::CMD_WRITE:   is_read = 1'b0; // write pushes an empty slot.
			afi_rd_pkg::CMD_REFRESH: is_read = 1'b0; // so does refresh.
			afi_rd_pkg::CMD_NOP:     is_read = 1'b0;
			default:                 is_read = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// latency shifter
	// bit k is set k+1 cycles after the read edge.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
		begin
			read_q          <= 1'b0;
			latency_shifter <= '0; // no reads in flight.
		end
		else
		begin
			read_q          <= is_read; // command register stage.
			latency_shifter <= {latency_shifter[`AFI_LAT_NUM-2:0], read_q}; // one tap per cycle.
		end
	end

	////////////////////////////////////////
	// outstanding reads
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
			reads_pending <= '0;
		else
		begin
			case ({is_read, read_valid})
				2'b10:   reads_pending <= reads_pending + 1'b1; // issued only.
				2'b01:   reads_pending <= reads_pending - 1'b1; // data due only.
				default: reads_pending <= reads_pending; // both or neither leave it.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== read_valid_selector.sv ====
////////////////////////////////////////
// read valid selector
// picks the shifter tap for the programmed latency
// and strobes read_enable and read_valid.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module read_valid_selector
(
	input  wire                        pll_afi_clk,
	input  wire                        reset_n,
	input  wire  [`AFI_LAT_NUM-1:0]    latency_shifter,
	input  wire  [`AFI_LAT_W-1:0]      rd_latency,
	output logic                       read_enable,
	output logic                       read_valid
);

	logic [`AFI_LAT_NUM-1:0] selector;     // one-hot latency decode.
	logic [`AFI_LAT_NUM-1:0] selector_reg; // decode, one cycle behind rd_latency.
	logic [`AFI_LAT_NUM-1:0] valid_select; // shifter masked to the chosen tap.

	////////////////////////////////////////
	// latency decode
	always_comb
	begin
		selector = '0;
		selector[rd_latency] = 1'b1; // one tap per setting.
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
			selector_reg <= '0; // no tap until out of reset.
		else
			selector_reg <= selector;
	end

	assign valid_select = selector_reg & latency_shifter; // hit on the due read.

	////////////////////////////////////////
	// strobes
	// both rise at edge t+2+rd_latency for a read at edge t.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
		begin
			read_enable <= 1'b0;
			read_valid  <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select; // toward the phy.
			read_valid  <= |valid_select; // capture strobe for the fifo.
		end
	end

endmodule

`default_nettype wire

// ==== read_data_fifo.sv ====
////////////////////////////////////////
// read data fifo
// circular buffer for returning memory words,
// written on read_valid, sticky flag on overflow.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module read_data_fifo
(
	input  wire                        pll_afi_clk,
	input  wire                        reset_n,
	input  wire                        read_valid,
	input  wire  [`AFI_WORD_W-1:0]     phy_rdata,
	input  wire                        fifo_pop,
	output logic [`AFI_WORD_W-1:0]     fifo_word,
	output logic                       fifo_empty,
	output logic                       fifo_overflow
);

	localparam int PTR_W = $clog2(`AFI_FIFO_DEPTH);     // entry index width.
	localparam int LVL_W = $clog2(`AFI_FIFO_DEPTH + 1); // level holds 0..depth.

	logic [`AFI_WORD_W-1:0] mem [`AFI_FIFO_DEPTH]; // word storage.
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [LVL_W-1:0]       level;      // words held.
	logic [LVL_W-1:0]       level_next;
	logic                   do_pop;     // pop of a real entry.
	logic                   do_push;    // accepted write.

	assign do_pop  = fifo_pop & ~fifo_empty;
	assign do_push = read_valid & ((level != LVL_W'(`AFI_FIFO_DEPTH)) | do_pop); // full drops.

	assign fifo_word = mem[rd_ptr]; // head entry.

	always_comb
	begin
		case ({do_push, do_pop})
			2'b10:   level_next = level + 1'b1;
			2'b01:   level_next = level - 1'b1;
			default: level_next = level;
		endcase
	end

	////////////////////////////////////////
	// storage
	always_ff @(posedge pll_afi_clk)
	begin
		if (do_push)
			mem[wr_ptr] <= phy_rdata; // capture on the due cycle.
	end

	////////////////////////////////////////
	// pointers and flags
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			level         <= '0;
			fifo_empty    <= 1'b1;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(`AFI_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`AFI_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			level      <= level_next;
			fifo_empty <= (level_next == '0); // registered, follows the write edge.
			if (read_valid & ~do_push)
				fifo_overflow <= 1'b1; // stays set until reset.
		end
	end

endmodule

`default_nettype wire

// ==== read_return_checker.sv ====
////////////////////////////////////////
// read return checker
// drains the fifo, checks even parity, counts
// returned reads and strobes each word out.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module read_return_checker
(
	input  wire                        pll_afi_clk,
	input  wire                        reset_n,
	input  wire                        fifo_empty,
	input  wire  [`AFI_WORD_W-1:0]     fifo_word,
	output logic                       fifo_pop,
	output logic [`AFI_DATA_W-1:0]     rd_data,
	output logic                       rd_data_valid,
	output logic                       parity_error,
	output logic [`AFI_CNT_W-1:0]      rd_count
);

	afi_rd_pkg::ret_state_e state;
	afi_rd_pkg::ret_state_e state_next;
	logic [`AFI_WORD_W-1:0] hold_word; // popped word waiting to go out.
	logic                   emit;      // held word leaves at this edge.

	assign fifo_pop = ~fifo_empty; // drain one per cycle, no hold-off.
	assign emit     = (state == afi_rd_pkg::RET_POP);

	////////////////////////////////////////
	// state machine
	always_comb
	begin
		case (state)
			afi_rd_pkg::RET_IDLE: state_next = fifo_pop ? afi_rd_pkg::RET_POP : afi_rd_pkg::RET_IDLE;
			afi_rd_pkg::RET_POP:  state_next = fifo_pop ? afi_rd_pkg::RET_POP : afi_rd_pkg::RET_EMIT;
			afi_rd_pkg::RET_EMIT: state_next = fifo_pop ? afi_rd_pkg::RET_POP : afi_rd_pkg::RET_IDLE;
			default:              state_next = afi_rd_pkg::RET_IDLE;
		endcase
	end

	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo_pop)
			hold_word <= fifo_word; // latch head as it is popped.
		if (emit)
			rd_data <= hold_word[`AFI_DATA_W-1:0];
	end

	////////////////////////////////////////
	// strobes and count
	// a new pop can land while the previous word goes out.
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (~reset_n)
		begin
			state         <= afi_rd_pkg::RET_IDLE;
			rd_data_valid <= 1'b0;
			parity_error  <= 1'b0;
			rd_count      <= '0;
		end
		else
		begin
			state         <= state_next;
			rd_data_valid <= emit;
			parity_error  <= emit & (^hold_word); // odd count of ones is bad.
			if (emit)
				rd_count <= rd_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== afi_read_path.sv ====
////////////////////////////////////////
// afi read path top
// tracker, valid selector, data fifo and checker.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module afi_read_path
(
	input  wire                        pll_afi_clk,
	input  wire                        reset_n,
	input  afi_rd_pkg::afi_cmd_e       afi_cmd,
	input  wire  [`AFI_LAT_W-1:0]      rd_latency,
	input  wire  [`AFI_WORD_W-1:0]     phy_rdata,
	output logic [`AFI_DATA_W-1:0]     rd_data,
	output logic                       rd_data_valid,
	output logic                       parity_error,
	output logic [`AFI_CNT_W-1:0]      rd_count,
	output logic [`AFI_PEND_W-1:0]     reads_pending,
	output logic                       fifo_overflow,
	output logic                       phy_read_enable
);

	logic [`AFI_LAT_NUM-1:0] latency_shifter; // reads in flight, one bit per cycle.
	logic                    read_valid;      // memory data due this cycle.
	logic                    fifo_empty;
	logic [`AFI_WORD_W-1:0]  fifo_word;       // head of the return buffer.
	logic                    fifo_pop;

	afi_cmd_tracker u_cmd_tracker
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_cmd         (afi_cmd),
		.read_valid      (read_valid),
		.latency_shifter (latency_shifter),
		.reads_pending   (reads_pending)
	);

	read_valid_selector u_valid_selector
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.rd_latency      (rd_latency),
		.read_enable     (phy_read_enable),
		.read_valid      (read_valid)
	);

	read_data_fifo u_data_fifo
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.read_valid      (read_valid),
		.phy_rdata       (phy_rdata),
		.fifo_pop        (fifo_pop),
		.fifo_word       (fifo_word),
		.fifo_empty      (fifo_empty),
		.fifo_overflow   (fifo_overflow)
	);

	read_return_checker u_return_checker
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.fifo_empty      (fifo_empty),
		.fifo_word       (fifo_word),
		.fifo_pop        (fifo_pop),
		.rd_data         (rd_data),
		.rd_data_valid   (rd_data_valid),
		.parity_error    (parity_error),
		.rd_count        (rd_count)
	);

endmodule

`default_nettype wire

// ==== tb_read_monitor.sv ====
////////////////////////////////////////
// read path monitor
// watches the read path outputs and compares them
// with the reads queued by the testbench.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module tb_read_monitor
(
	input  wire                        pll_afi_clk,
	input  wire  [31:0]                cycle,
	input  wire  [`AFI_DATA_W-1:0]     rd_data,
	input  wire                        rd_data_valid,
	input  wire                        parity_error,
	input  wire  [`AFI_CNT_W-1:0]      rd_count,
	input  wire  [`AFI_PEND_W-1:0]     reads_pending,
	input  wire                        fifo_overflow,
	input  wire                        phy_read_enable
);

	int                     error_count = 0;
	bit                     overflow_seen = 1'b0; // report the flag once.
	int                     q_name [$];           // test index per read.
	logic [`AFI_DATA_W-1:0] q_data [$];
	bit                     q_perr [$];
	int                     q_valid_cyc [$];      // edge of rd_data_valid.
	int                     q_en_cyc [$];         // edge of phy_read_enable.
	int                     q_en_name [$];        // test index per phy strobe.

	// one read issued at edge read_edge.
	task automatic expect_read(input int name, input logic [`AFI_DATA_W-1:0] data,
		input bit perr, input int read_edge, input int lat);
	begin
		q_name.push_back(name);
		q_data.push_back(data);
		q_perr.push_back(perr);
		q_valid_cyc.push_back(read_edge + 5 + lat); // full return path.
		q_en_cyc.push_back(read_edge + 2 + lat);    // phy strobe.
		q_en_name.push_back(name);
	end
	endtask

	function automatic int outstanding();
		return q_data.size();
	endfunction

	// counter back at zero once nothing is in flight.
	task automatic check_idle(input int name);
	begin
		if (reads_pending !== '0)
		begin
			$display("FAILED test %0d reads_pending expected %0d actual %0d",
				name, 0, reads_pending);
			error_count++;
		end
		if (q_en_cyc.size() != 0)
		begin
			$display("phy_read_enable never came for %0d reads before test %0d",
				q_en_cyc.size(), name);
			error_count++;
		end
	end
	endtask

	task automatic check_count(input int expected);
	begin
		if (rd_count !== `AFI_CNT_W'(expected))
		begin
			$display("FAILED test end rd_count expected %0d actual %0d", expected, rd_count);
			error_count++;
		end
	end
	endtask

	////////////////////////////////////////
	// sampled mid-cycle away from the edge.
	always @(negedge pll_afi_clk)
	begin : watch
		int name;
		int due;
		logic [`AFI_DATA_W-1:0] data;
		bit perr;
		if (phy_read_enable)
		begin
			if (q_en_cyc.size() == 0)
			begin
				$display("phy_read_enable rose at cycle %0d with no read due", cycle);
				error_count++;
			end
			else
			begin
				due  = q_en_cyc.pop_front();
				name = q_en_name.pop_front();
				if (due != cycle)
				begin
					$display("FAILED test %0d phy_read_enable cycle expected %0d actual %0d",
						name, due, cycle);
					error_count++;
				end
			end
		end
		if (rd_data_valid)
		begin
			if (q_data.size() == 0)
			begin
				$display("rd_data_valid rose at cycle %0d with no read outstanding", cycle);
				error_count++;
			end
			else
			begin
				name = q_name.pop_front();
				data = q_data.pop_front();
				perr = q_perr.pop_front();
				due  = q_valid_cyc.pop_front();
				if (rd_data !== data)
				begin
					$display("FAILED test %0d rd_data expected %h actual %h", name, data, rd_data);
					error_count++;
				end
				if (parity_error !== perr)
				begin
					$display("FAILED test %0d parity_error expected %0d actual %0d",
						name, perr, parity_error);
					error_count++;
				end
				if (due != cycle)
				begin
					$display("FAILED test %0d valid cycle expected %0d actual %0d",
						name, due, cycle);
					error_count++;
				end
			end
		end
		else if (parity_error)
		begin
			$display("parity_error rose at cycle %0d without rd_data_valid", cycle);
			error_count++;
		end
		if (fifo_overflow && !overflow_seen)
		begin
			$display("fifo_overflow went high at cycle %0d", cycle);
			overflow_seen = 1'b1;
			error_count++;
		end
	end

endmodule

`default_nettype wire

// ==== tb_afi_read_path.sv ====
////////////////////////////////////////
// afi read path testbench
// file driven reads, memory model, timeout.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "afi_rd_macros.svh"

module tb_afi_read_path;

	localparam int MAX_TESTS = 32;
	localparam int FIELDS    = 5; // index, latency, idle, data, corrupt.

	logic                       pll_afi_clk = 1'b0;
	logic                       reset_n = 1'b0;
	afi_rd_pkg::afi_cmd_e       afi_cmd = afi_rd_pkg::CMD_NOP;
	logic [`AFI_LAT_W-1:0]      rd_latency = '0;
	logic [`AFI_WORD_W-1:0]     phy_rdata = '0;
	logic [`AFI_DATA_W-1:0]     rd_data;
	logic                       rd_data_valid;
	logic                       parity_error;
	logic [`AFI_CNT_W-1:0]      rd_count;
	logic [`AFI_PEND_W-1:0]     reads_pending;
	logic                       fifo_overflow;
	logic                       phy_read_enable;

	logic [31:0]            stim [MAX_TESTS*FIELDS]; // flat table from the data file.
	logic [31:0]            cycle = '0;              // rising edges seen.
	int                     limit = 0;               // timeout cycle once the file is read.
	integer                 seed = 32'heabe_b83b;
	int                     q_mem_due [$];           // memory model schedule.
	logic [`AFI_WORD_W-1:0] q_mem_word [$];

	afi_read_path DUT
	(
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.afi_cmd         (afi_cmd),
		.rd_latency      (rd_latency),
		.phy_rdata       (phy_rdata),
		.rd_data         (rd_data),
		.rd_data_valid   (rd_data_valid),
		.parity_error    (parity_error),
		.rd_count        (rd_count),
		.reads_pending   (reads_pending),
		.fifo_overflow   (fifo_overflow),
		.phy_read_enable (phy_read_enable)
	);

	tb_read_monitor mon
	(
		.pll_afi_clk     (pll_afi_clk),
		.cycle           (cycle),
		.rd_data         (rd_data),
		.rd_data_valid   (rd_data_valid),
		.parity_error    (parity_error),
		.rd_count        (rd_count),
		.reads_pending   (reads_pending),
		.fifo_overflow   (fifo_overflow),
		.phy_read_enable (phy_read_enable)
	);

	always #20 pll_afi_clk = ~pll_afi_clk; // 40 ns period.

	////////////////////////////////////////
	// cycle count and timeout
	always @(posedge pll_afi_clk)
	begin
		cycle <= cycle + 1'b1;
		if (limit != 0 && cycle >= limit)
		begin
			$display("timeout after %0d cycles, reads still outstanding: %0d",
				cycle, mon.outstanding());
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// memory model drives data on the due cycle.
	always @(negedge pll_afi_clk)
	begin
		if (q_mem_due.size() != 0 && q_mem_due[0] == cycle)
		begin
			phy_rdata <= q_mem_word.pop_front();
			void'(q_mem_due.pop_front());
		end
		else
			phy_rdata <= {$random(seed), 1'b1}; // junk that must never be captured.
	end

	// idle slot filled with a random non-read command.
	task automatic drive_background();
		int pick;
	begin
		pick = ($random(seed) & 32'h7fff_ffff) % 3;
		case (pick)
			0:       afi_cmd = afi_rd_pkg::CMD_NOP;
			1:       afi_cmd = afi_rd_pkg::CMD_WRITE;
			default: afi_cmd = afi_rd_pkg::CMD_REFRESH;
		endcase
	end
	endtask

	// wait for all reads to return.
	task automatic drain_reads(input int name);
	begin
		afi_cmd = afi_rd_pkg::CMD_NOP;
		while (mon.outstanding() != 0)
			@(negedge pll_afi_clk);
		@(negedge pll_afi_clk);
		mon.check_idle(name);
	end
	endtask

	initial
	begin : stimulus
		int n;
		int total;
		int i;
		int lat;
		logic [`AFI_DATA_W-1:0] data;
		logic par;
		$readmemh("afi_read_stim.txt", stim);
		n = 0;
		total = 0;
		while (n < MAX_TESTS && !$isunknown(stim[n*FIELDS]))
		begin
			total += stim[n*FIELDS+1] + stim[n*FIELDS+2];
			n++;
		end
		limit = total + 100 + 8;
		repeat (8) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset_n = 1'b1;
		@(negedge pll_afi_clk);
		for (i = 0; i < n; i++)
		begin
			lat = stim[i*FIELDS+1];
			if (lat != rd_latency)
			begin
				drain_reads(stim[i*FIELDS]);
				repeat (`AFI_LAT_NUM) @(negedge pll_afi_clk); // old reads leave the shifter.
				rd_latency = lat[`AFI_LAT_W-1:0];
				repeat (2) @(negedge pll_afi_clk); // selector register settles.
			end
			repeat (stim[i*FIELDS+2])
			begin
				drive_background();
				@(negedge pll_afi_clk);
			end
			data = stim[i*FIELDS+3];
			par  = (^data) ^ stim[i*FIELDS+4][0]; // even parity flipped on corrupt.
			afi_cmd = afi_rd_pkg::CMD_READ;
			q_mem_due.push_back(cycle + 1 + 2 + lat);
			q_mem_word.push_back({par, data});
			mon.expect_read(stim[i*FIELDS], data, stim[i*FIELDS+4][0], cycle + 1, lat);
			@(negedge pll_afi_clk);
		end
		drain_reads(n);
		mon.check_count(n);
		$display("done: %0d reads, %0d errors", n, mon.error_count);
		if (mon.error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== afi_read_stim.txt ====
// one read per line, all hex: index latency idle_cycles data corrupt
// latency held across lines, changed only after the path drains
01 0 3 1234abcd 0
02 0 0 00000000 0
03 0 0 ffffffff 1
04 0 0 a5a5a5a5 0
05 0 5 0badf00d 1
06 5 2 deadbeef 0
07 5 0 13579bdf 0
08 5 0 2468ace0 1
09 5 0 80000001 0
0a 5 7 7fffffff 0
0b f 1 cafef00d 0
0c f 0 55aa55aa 1
0d f 0 00000001 0
0e f 0 fedcba98 0
0f f 4 0f0f0f0f 1
10 0 2 c001d00d 0
11 0 0 31415926 0

// ==== src.f ====
+incdir+.
afi_rd_pkg.sv
afi_cmd_tracker.sv
read_valid_selector.sv
read_data_fifo.sv
read_return_checker.sv
afi_read_path.sv
tb_read_monitor.sv
tb_afi_read_path.sv

// ==== Bender.yml ====
package:
  name: afi_read_path

sources:
  - include_dirs:
      - .
    files:
      - afi_rd_pkg.sv
      - afi_cmd_tracker.sv
      - read_valid_selector.sv
      - read_data_fifo.sv
      - read_return_checker.sv
      - afi_read_path.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_read_monitor.sv
      - tb_afi_read_path.sv
